/* Bender.yml */
package:
  name: store_subsystem

sources:
  - include_dirs:
      - include
    files:
      - hw/store_pkg.sv
      - hw/rr_arbiter.sv
      - hw/l1_store_queue.sv
      - hw/l2_store_port.sv
      - hw/store_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/store_tb.sv

/* bench/store_tb.sv */
/*
 * Testbench for the store path top level.
 * Clock and reset, LFSR stimulus, a shadow model of line memory and
 * reservations, compare tasks and a watchdog.
 */

`timescale 1ns/100ps

`include "core_config.svh"

module store_tb;
	import store_pkg::*;

	localparam CLK_PERIOD = 100;
	localparam NUM_THREADS = `THREADS_PER_CORE;
	localparam L2_LATENCY = `L2_DEFAULT_LATENCY;
	localparam MEM_IDX_BITS = $clog2(MEM_LINES);
	localparam TEST_CYCLES = 400;
	localparam WAIT_LIMIT = 4 * L2_LATENCY + 16;

	logic clk;
	logic reset;
	store_request_t store;
	l1d_addr_t bypass_addr;
	thread_idx_t bypass_thread;
	line_mask_t bypass_mask;
	cache_line_t bypass_data;
	logic sync_success;
	logic rollback_en;
	logic [NUM_THREADS - 1:0] wake_bitmap;
	logic reserve_en;
	thread_idx_t reserve_thread;
	l1d_addr_t reserve_addr;
	logic [MEM_IDX_BITS - 1:0] mem_read_addr;
	cache_line_t mem_read_data;

	// Shadow state of the L2 side
	cache_line_t mem_model [MEM_LINES];
	logic [NUM_THREADS - 1:0] res_valid_model;
	l1d_addr_t res_line_model [NUM_THREADS];
	logic [31:0] lfsr_state;

	store_subsystem #(
		.NUM_THREADS(NUM_THREADS),
		.L2_LATENCY(L2_LATENCY)
	) DUT (
		.clk(clk),
		.reset(reset),
		.store(store),
		.bypass_addr(bypass_addr),
		.bypass_thread(bypass_thread),
		.bypass_mask(bypass_mask),
		.bypass_data(bypass_data),
		.sync_success(sync_success),
		.rollback_en(rollback_en),
		.wake_bitmap(wake_bitmap),
		.reserve_en(reserve_en),
		.reserve_thread(reserve_thread),
		.reserve_addr(reserve_addr),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Galois form, taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	function automatic logic [127:0] take_bits(input int count);
		logic [127:0] value;

		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	function automatic l1d_addr_t line_of(input l1d_addr_t a);
		l1d_addr_t line;

		line = a;
		line.offset = '0;
		return line;
	endfunction

	function automatic l1d_addr_t random_addr(input int set);
		logic [127:0] bits;
		l1d_addr_t a;

		bits = take_bits(32);
		a = bits[31:0];
		a.set_idx = 6'(set);
		return a;
	endfunction

	// At least one byte enabled, so a live entry always shows in bypass
	function automatic line_mask_t random_mask();
		logic [127:0] bits;
		line_mask_t m;

		bits = take_bits(20);
		m = bits[15:0];
		m[bits[19:16]] = 1'b1;
		return m;
	endfunction

	function automatic cache_line_t merged_line(input cache_line_t old, input line_mask_t mask,
		input cache_line_t data);
		cache_line_t line;

		line = old;
		for (int b = 0; b < $bits(line_mask_t); b++)
		begin
			if (mask[b])
				line[b * 8 +: 8] = data[b * 8 +: 8];
		end
		return line;
	endfunction

	function automatic logic expected_sync(input thread_idx_t t, input l1d_addr_t a);
		return res_valid_model[t] && res_line_model[t] == line_of(a);
	endfunction

	// Applied in answer order; a failed sync store changes nothing
	task automatic model_commit(input thread_idx_t t, input l1d_addr_t a, input line_mask_t m,
		input cache_line_t d, input logic sync);
		int idx;

		idx = int'(a.set_idx) % MEM_LINES;
		if (!sync || expected_sync(t, a))
		begin
			mem_model[idx] = merged_line(mem_model[idx], m, d);
			for (int i = 0; i < NUM_THREADS; i++)
			begin
				if (res_line_model[i] == line_of(a))
					res_valid_model[i] = 1'b0;
			end
		end
	endtask

	task end_with_failure();
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task compare_line(input cache_line_t got, input cache_line_t expected, input string what);
		if (got !== expected)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
			end_with_failure();
		end
	endtask

	task compare_mask(input line_mask_t got, input line_mask_t expected, input string what);
		if (got !== expected)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
			end_with_failure();
		end
	endtask

	task compare_bit(input logic got, input logic expected, input string what);
		if (got !== expected)
		begin
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, expected);
			end_with_failure();
		end
	endtask

	task drive_store(input thread_idx_t t, input l1d_addr_t a, input line_mask_t m,
		input cache_line_t d, input logic sync);
		@(posedge clk);
		store <= '{en: 1'b1, addr: a, mask: m, data: d, synchronized: sync, thread: t};
	endtask

	task end_store();
		@(posedge clk);
		store.en <= 1'b0;
	endtask

	task point_bypass(input thread_idx_t t, input l1d_addr_t a);
		bypass_thread <= t;
		bypass_addr <= a;
	endtask

	task reserve(input thread_idx_t t, input l1d_addr_t a);
		@(posedge clk);
		reserve_en <= 1'b1;
		reserve_thread <= t;
		reserve_addr <= a;
		@(posedge clk);
		reserve_en <= 1'b0;
		res_valid_model[t] = 1'b1;
		res_line_model[t] = line_of(a);
	endtask

	task settle();
		repeat (L2_LATENCY + 2) @(posedge clk);
	endtask

	task check_memory(input l1d_addr_t a, input string what);
		@(posedge clk);
		mem_read_addr <= MEM_IDX_BITS'(a.set_idx % MEM_LINES);
		@(posedge clk);
		@(negedge clk);
		compare_line(mem_read_data, mem_model[int'(a.set_idx) % MEM_LINES], what);
	endtask

	// The entry drops out of bypass once its answer is back
	task automatic wait_retired(input thread_idx_t t, input l1d_addr_t a);
		int cycles;

		@(posedge clk);
		point_bypass(t, a);
		@(posedge clk);
		@(negedge clk);
		cycles = 0;
		while (bypass_mask != '0)
		begin
			cycles++;
			if (cycles > WAIT_LIMIT)
			begin
				$display("timeout: store of thread %0d never retired", t);
				end_with_failure();
			end
			@(negedge clk);
		end
	endtask

	// Called at a falling edge, so an answer in the current cycle is seen
	task automatic wait_wake(input thread_idx_t t);
		int cycles;

		cycles = 0;
		while (!wake_bitmap[t])
		begin
			cycles++;
			if (cycles > WAIT_LIMIT)
			begin
				$display("timeout: thread %0d was never woken", t);
				end_with_failure();
			end
			@(negedge clk);
		end
		for (int i = 0; i < NUM_THREADS; i++)
			compare_bit(wake_bitmap[i], thread_idx_t'(i) == t, "wake bitmap bit");
	endtask

	// Second store arrives while the first entry is busy, in its send cycle at the earliest
	task automatic store_twice(input thread_idx_t t, input l1d_addr_t addr_a,
		input l1d_addr_t addr_b);
		line_mask_t mask_a;
		line_mask_t mask_b;
		cache_line_t data_a;
		cache_line_t data_b;

		mask_a = random_mask();
		mask_b = random_mask();
		data_a = take_bits(128);
		data_b = take_bits(128);
		drive_store(t, addr_a, mask_a, data_a, 1'b0);
		point_bypass(t, addr_a);
		drive_store(t, addr_b, mask_b, data_b, 1'b0);
		end_store();
		@(negedge clk);
		compare_bit(rollback_en, 1'b1, "rollback of store to a busy entry");
		compare_mask(bypass_mask, mask_a, "bypass mask");
		compare_line(merged_line('0, mask_a, bypass_data), merged_line('0, mask_a, data_a),
			"bypass data");
		wait_wake(t);
		model_commit(t, addr_a, mask_a, data_a, 1'b0);
		drive_store(t, addr_b, mask_b, data_b, 1'b0);
		end_store();
		@(negedge clk);
		compare_bit(rollback_en, 1'b0, "rollback of retried store");
		wait_retired(t, addr_b);
		model_commit(t, addr_b, mask_b, data_b, 1'b0);
		settle();
		check_memory(addr_a, "first line after retry");
		check_memory(addr_b, "second line after retry");
	endtask

	task automatic sync_attempt(input thread_idx_t t, input l1d_addr_t a, input string what);
		line_mask_t m;
		cache_line_t d;
		logic expected;

		m = random_mask();
		d = take_bits(128);
		drive_store(t, a, m, d, 1'b1);
		end_store();
		@(negedge clk);
		compare_bit(rollback_en, 1'b1, "rollback of first sync attempt");
		wait_wake(t);
		expected = expected_sync(t, a);
		model_commit(t, a, m, d, 1'b1);
		drive_store(t, a, m, d, 1'b1);
		end_store();
		@(negedge clk);
		compare_bit(rollback_en, 1'b0, "rollback of sync retry");
		compare_bit(sync_success, expected, what);
		settle();
		check_memory(a, what);
	endtask

	initial
	begin
		#((TEST_CYCLES * 4 + 200) * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		end_with_failure();
	end

	initial
	begin
		l1d_addr_t addr_a;
		l1d_addr_t addr_b;
		l1d_addr_t round_addr [NUM_THREADS];
		line_mask_t round_mask [NUM_THREADS];
		cache_line_t round_data [NUM_THREADS];
		line_mask_t other_mask;
		cache_line_t other_data;

		clk = 1'b0;
		reset = 1'b1;
		store = '0;
		bypass_addr = '0;
		bypass_thread = '0;
		reserve_en = 1'b0;
		reserve_thread = '0;
		reserve_addr = '0;
		mem_read_addr = '0;
		lfsr_state = 32'ha846fcd2;
		res_valid_model = '0;
		for (int i = 0; i < MEM_LINES; i++)
			mem_model[i] = '0;
		for (int i = 0; i < NUM_THREADS; i++)
			res_line_model[i] = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// Every thread stores in back to back cycles, then all retire
		for (int round = 0; round < 3; round++)
		begin
			for (int i = 0; i < NUM_THREADS; i++)
			begin
				round_addr[i] = random_addr(int'(take_bits(4)));
				round_mask[i] = random_mask();
				round_data[i] = take_bits(128);
				drive_store(thread_idx_t'(i), round_addr[i], round_mask[i], round_data[i], 1'b0);
			end
			end_store();
			for (int i = 0; i < NUM_THREADS; i++)
			begin
				wait_retired(thread_idx_t'(i), round_addr[i]);
				model_commit(thread_idx_t'(i), round_addr[i], round_mask[i], round_data[i], 1'b0);
			end
			settle();
			for (int i = 0; i < NUM_THREADS; i++)
				check_memory(round_addr[i], "plain store line");
		end

		// Same line twice; the port never stalls, so the entry is already being sent
		addr_a = random_addr(7);
		store_twice(2, addr_a, addr_a);

		addr_a = random_addr(5);
		addr_b = random_addr(6);
		store_twice(1, addr_a, addr_b);

		// Reservation on the same line at another byte offset
		addr_a = random_addr(9);
		addr_b = addr_a;
		addr_b.offset = ~addr_a.offset;
		reserve(3, addr_b);
		sync_attempt(3, addr_a, "sync store with reservation");

		// Thread 1 writes the line and breaks the reservation of thread 0
		addr_a = random_addr(11);
		reserve(0, addr_a);
		other_mask = random_mask();
		other_data = take_bits(128);
		drive_store(1, addr_a, other_mask, other_data, 1'b0);
		model_commit(1, addr_a, other_mask, other_data, 1'b0);
		end_store();
		wait_retired(1, addr_a);
		sync_attempt(0, addr_a, "sync store with broken reservation");

		$display("TESTS PASSED");
		$finish;
	end
endmodule

/* flist.f */
+incdir+include
hw/store_pkg.sv
hw/rr_arbiter.sv
hw/l1_store_queue.sv
hw/l2_store_port.sv
hw/store_subsystem.sv
bench/store_tb.sv

/* hw/l1_store_queue.sv */
/*
 * L1 store queue with one pending line store per thread.
 * Write combining, rollback and wake of threads, bypass to later loads,
 * synchronized store results and round-robin dequeue to the L2 port.
 */

`timescale 1ns/100ps

module l1_store_queue #(
	parameter NUM_THREADS = 4
) (
	input clk,
	input reset,

	// From the data cache stage
	input store_pkg::store_request_t store,
	input store_pkg::l1d_addr_t bypass_addr,
	input store_pkg::thread_idx_t bypass_thread,

	// To the writeback stage
	output store_pkg::line_mask_t bypass_mask,
	output store_pkg::cache_line_t bypass_data,
	output logic sync_success,
	output logic rollback_en,
	output logic [NUM_THREADS - 1:0] wake_bitmap,

	// To and from the L2 port
	output logic dequeue_ready,
	output store_pkg::l2_request_t dequeue_request,
	input dequeue_ack,
	input store_pkg::l2_response_t l2_response
);
	import store_pkg::*;

	typedef struct packed {
		logic synchronized;
		logic sent;
		logic answered;
		logic success;
		logic waiting;
		logic valid;
	} entry_state_t;

	typedef struct packed {
		cache_line_t data;
		line_mask_t mask;
		l1d_addr_t addr;
	} entry_payload_t;

	entry_state_t state [NUM_THREADS];
	entry_payload_t payload [NUM_THREADS];
	logic [NUM_THREADS - 1:0] send_request;
	logic [NUM_THREADS - 1:0] grant_oh;
	logic [NUM_THREADS - 1:0] rollback;
	logic [NUM_THREADS - 1:0] sync_result;
	thread_idx_t grant_idx;
	l1d_addr_t store_line;
	l1d_addr_t bypass_line;

	// Entries are tracked per line, so drop the byte offset
	assign store_line = '{tag: store.addr.tag, set_idx: store.addr.set_idx, offset: '0};
	assign bypass_line = '{tag: bypass_addr.tag, set_idx: bypass_addr.set_idx, offset: '0};

	rr_arbiter #(
		.NUM_THREADS(NUM_THREADS)
	) send_arbiter (
		.clk(clk),
		.reset(reset),
		.request(send_request),
		.grant_oh(grant_oh),
		.grant_idx(grant_idx)
	);

	for (genvar t = 0; t < NUM_THREADS; t++)
	begin : thread_entry
		logic this_store;
		logic send_now;
		logic resp_hit;
		logic busy;
		logic can_combine;
		logic restart;
		logic update;

		assign this_store = store.en && store.thread == thread_idx_t'(t);
		assign send_now = grant_oh[t] && dequeue_ack;
		assign resp_hit = l2_response.valid && l2_response.idx == l1_miss_entry_idx_t'(t);

		// A plain entry answered this cycle is free for a new store
		assign busy = state[t].valid && !(resp_hit && !state[t].synchronized);

		// Merging stops once the entry has been handed to the L2 port
		assign can_combine = state[t].valid && !state[t].sent && !state[t].synchronized
			&& !store.synchronized && !send_now && payload[t].addr == store_line;

		// Retry of a synchronized store whose answer is already back
		assign restart = state[t].valid && state[t].synchronized && state[t].answered;

		assign update = this_store && !restart && (!busy || can_combine);
		assign send_request[t] = state[t].valid && !state[t].sent;
		assign wake_bitmap[t] = resp_hit && state[t].waiting;
		assign sync_result[t] = this_store && store.synchronized && restart && state[t].success;

		// A first synchronized attempt always suspends, as it must wait for L2
		assign rollback[t] = this_store
			&& (store.synchronized ? !restart : busy && !can_combine);

		always_ff @(posedge clk, posedge reset)
		begin
			if (reset)
				state[t] <= '0;
			else
			begin
				if (send_now)
					state[t].sent <= 1'b1;

				if (resp_hit)
				begin
					// A synchronized entry lives on until the thread collects the result
					if (state[t].synchronized)
					begin
						state[t].answered <= 1'b1;
						state[t].success <= l2_response.sync_success;
					end
					else
						state[t].valid <= 1'b0;
				end

				if (wake_bitmap[t])
					state[t].waiting <= 1'b0;
				if (rollback[t])
					state[t].waiting <= 1'b1;

				if (this_store && restart)
					state[t].valid <= 1'b0;
				else if (update && !can_combine)
				begin
					state[t] <= '{
						synchronized: store.synchronized,
						sent: 1'b0,
						answered: 1'b0,
						success: 1'b0,
						waiting: rollback[t],
						valid: 1'b1
					};
				end
			end
		end

		always_ff @(posedge clk)
		begin
			if (update)
			begin
				for (int b = 0; b < $bits(line_mask_t); b++)
				begin
					if (store.mask[b])
						payload[t].data[b * 8 +: 8] <= store.data[b * 8 +: 8];
				end
				payload[t].mask <= can_combine ? payload[t].mask | store.mask : store.mask;
				payload[t].addr <= store_line;
			end
		end
	end

	// The granted entry goes straight out, no output register
	assign dequeue_ready = |grant_oh;
	assign dequeue_request.op = state[grant_idx].synchronized ? l2_store_sync : l2_store;
	assign dequeue_request.addr = payload[grant_idx].addr;
	assign dequeue_request.idx = grant_idx;
	assign dequeue_request.mask = payload[grant_idx].mask;
	assign dequeue_request.data = payload[grant_idx].data;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			bypass_mask <= '0;
			sync_success <= 1'b0;
			rollback_en <= 1'b0;
		end
		else
		begin
			if (state[bypass_thread].valid && payload[bypass_thread].addr == bypass_line)
				bypass_mask <= payload[bypass_thread].mask;
			else
				bypass_mask <= '0;
			sync_success <= |sync_result;
			rollback_en <= |rollback;
		end
	end

	// Data is only meaningful where bypass_mask is set
	always_ff @(posedge clk)
		bypass_data <= payload[bypass_thread].data;
endmodule

/* hw/l2_store_port.sv */
/*
 * Simplified L2 store port.
 * Fixed-latency answer pipeline, per-thread load-linked reservations,
 * a small line memory and its registered read port.
 */

`timescale 1ns/100ps

module l2_store_port #(
	parameter NUM_THREADS = 4,
	parameter L2_LATENCY = 4
) (
	input clk,
	input reset,

	// From the store queue
	input store_pkg::l2_request_t request,
	input request_valid,
	output logic ack,
	output store_pkg::l2_response_t response,

	// Load-linked reservations
	input reserve_en,
	input store_pkg::thread_idx_t reserve_thread,
	input store_pkg::l1d_addr_t reserve_addr,

	// Line memory read port
	input [$clog2(store_pkg::MEM_LINES) - 1:0] mem_read_addr,
	output store_pkg::cache_line_t mem_read_data
);
	import store_pkg::*;

	localparam MEM_IDX_BITS = $clog2(MEM_LINES);

	logic [L2_LATENCY - 1:0] pipe_valid;
	l2_request_t pipe_req [L2_LATENCY];
	logic [NUM_THREADS - 1:0] res_valid;
	l1d_addr_t res_addr [NUM_THREADS];
	cache_line_t mem [MEM_LINES];
	l2_request_t done_req;
	logic done_valid;
	logic is_sync;
	logic reserved;
	logic commit;
	logic [MEM_IDX_BITS - 1:0] done_line;
	l1d_addr_t reserve_line;

	// Never back-pressured, so every offered store is taken at once
	assign ack = request_valid;

	assign reserve_line = '{tag: reserve_addr.tag, set_idx: reserve_addr.set_idx, offset: '0};

	// The last pipeline stage is the answer cycle
	assign done_valid = pipe_valid[L2_LATENCY - 1];
	assign done_req = pipe_req[L2_LATENCY - 1];
	assign is_sync = done_req.op == l2_store_sync;
	assign reserved = res_valid[done_req.idx] && res_addr[done_req.idx] == done_req.addr;
	assign commit = done_valid && (!is_sync || reserved);
	assign done_line = MEM_IDX_BITS'(done_req.addr.set_idx % MEM_LINES);

	assign response.valid = done_valid;
	assign response.idx = done_req.idx;
	assign response.sync_success = done_valid && is_sync && reserved;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			pipe_valid <= '0;
		else
		begin
			pipe_valid[0] <= request_valid && ack;
			for (int i = 1; i < L2_LATENCY; i++)
				pipe_valid[i] <= pipe_valid[i - 1];
		end
	end

	always_ff @(posedge clk)
	begin
		pipe_req[0] <= request;
		for (int i = 1; i < L2_LATENCY; i++)
			pipe_req[i] <= pipe_req[i - 1];
	end

	// A committed write breaks every reservation on its line
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			res_valid <= '0;
		else
		begin
			for (int t = 0; t < NUM_THREADS; t++)
			begin
				if (commit && res_addr[t] == done_req.addr)
					res_valid[t] <= 1'b0;
			end
			if (reserve_en)
				res_valid[reserve_thread] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reserve_en)
			res_addr[reserve_thread] <= reserve_line;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < MEM_LINES; i++)
				mem[i] <= '0;
		end
		else if (commit)
		begin
			for (int b = 0; b < $bits(line_mask_t); b++)
			begin
				if (done_req.mask[b])
					mem[done_line][b * 8 +: 8] <= done_req.data[b * 8 +: 8];
			end
		end
	end

	always_ff @(posedge clk)
		mem_read_data <= mem[mem_read_addr];
endmodule

/* hw/rr_arbiter.sv */
/*
 * Round-robin arbiter.
 * Grants the first requester after the last winner and encodes the
 * granted index alongside the one-hot grant.
 */

`timescale 1ns/100ps

module rr_arbiter #(
	parameter NUM_THREADS = 4
) (
	input clk,
	input reset,
	input [NUM_THREADS - 1:0] request,
	output logic [NUM_THREADS - 1:0] grant_oh,
	output store_pkg::thread_idx_t grant_idx
);
	import store_pkg::*;

	thread_idx_t last_grant;

	// Scan starting one past the last winner, wrapping around
	always_comb
	begin
		int slot;
		logic found;

		found = 1'b0;
		grant_oh = '0;
		grant_idx = '0;
		for (int i = 1; i <= NUM_THREADS; i++)
		begin
			slot = (int'(last_grant) + i) % NUM_THREADS;
			if (!found && request[slot])
			begin
				found = 1'b1;
				grant_oh[slot] = 1'b1;
				grant_idx = thread_idx_t'(slot);
			end
		end
	end

	// Start so that thread 0 has top priority out of reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_grant <= thread_idx_t'(NUM_THREADS - 1);
		else if (|request)
			last_grant <= grant_idx;
	end
endmodule

/* hw/store_pkg.sv */
/*
 * Shared types for the store path.
 * Address, line, thread and mask types, core and L2 request and response
 * structs, the L2 opcode enum and the line memory size.
 */

`include "core_config.svh"

package store_pkg;
	localparam LINE_BYTES = `CACHE_LINE_BYTES;
	localparam LINE_BITS = LINE_BYTES * 8;
	localparam OFFSET_BITS = $clog2(LINE_BYTES);
	localparam SET_BITS = 6;
	localparam THREAD_IDX_BITS = $clog2(`THREADS_PER_CORE);

	// Lines held by the simplified L2 line memory
	localparam MEM_LINES = 16;

	typedef logic [31:0] scalar_t;
	typedef logic [THREAD_IDX_BITS - 1:0] thread_idx_t;
	typedef logic [LINE_BITS - 1:0] cache_line_t;
	typedef logic [LINE_BYTES - 1:0] line_mask_t;

	// A byte address; a line address has the offset cleared
	typedef struct packed {
		logic [$bits(scalar_t) - SET_BITS - OFFSET_BITS - 1:0] tag;
		logic [SET_BITS - 1:0] set_idx;
		logic [OFFSET_BITS - 1:0] offset;
	} l1d_addr_t;

	// One outstanding L2 transaction per thread, so the tag is the thread
	typedef thread_idx_t l1_miss_entry_idx_t;

	typedef enum logic {
		l2_store,
		l2_store_sync
	} l2_op_t;

	typedef struct packed {
		logic en;
		l1d_addr_t addr;
		line_mask_t mask;
		cache_line_t data;
		logic synchronized;
		thread_idx_t thread;
	} store_request_t;

	typedef struct packed {
		l2_op_t op;
		l1d_addr_t addr;
		l1_miss_entry_idx_t idx;
		line_mask_t mask;
		cache_line_t data;
	} l2_request_t;

	typedef struct packed {
		logic valid;
		l1_miss_entry_idx_t idx;
		logic sync_success;
	} l2_response_t;
endpackage

/* hw/store_subsystem.sv */
/*
 * Store path top level.
 * Connects the L1 store queue to the simplified L2 store port.
 */

`timescale 1ns/100ps

`include "core_config.svh"

module store_subsystem #(
	parameter NUM_THREADS = `THREADS_PER_CORE,
	parameter L2_LATENCY = `L2_DEFAULT_LATENCY
) (
	input clk,
	input reset,
	input store_pkg::store_request_t store,
	input store_pkg::l1d_addr_t bypass_addr,
	input store_pkg::thread_idx_t bypass_thread,
	output store_pkg::line_mask_t bypass_mask,
	output store_pkg::cache_line_t bypass_data,
	output logic sync_success,
	output logic rollback_en,
	output logic [NUM_THREADS - 1:0] wake_bitmap,
	input reserve_en,
	input store_pkg::thread_idx_t reserve_thread,
	input store_pkg::l1d_addr_t reserve_addr,
	input [$clog2(store_pkg::MEM_LINES) - 1:0] mem_read_addr,
	output store_pkg::cache_line_t mem_read_data
);
	import store_pkg::*;

	logic dequeue_ready;
	logic dequeue_ack;
	l2_request_t dequeue_request;
	l2_response_t l2_response;

	l1_store_queue #(
		.NUM_THREADS(NUM_THREADS)
	) store_queue (
		.clk(clk),
		.reset(reset),
		.store(store),
		.bypass_addr(bypass_addr),
		.bypass_thread(bypass_thread),
		.bypass_mask(bypass_mask),
		.bypass_data(bypass_data),
		.sync_success(sync_success),
		.rollback_en(rollback_en),
		.wake_bitmap(wake_bitmap),
		.dequeue_ready(dequeue_ready),
		.dequeue_request(dequeue_request),
		.dequeue_ack(dequeue_ack),
		.l2_response(l2_response)
	);

	l2_store_port #(
		.NUM_THREADS(NUM_THREADS),
		.L2_LATENCY(L2_LATENCY)
	) l2_port (
		.clk(clk),
		.reset(reset),
		.request(dequeue_request),
		.request_valid(dequeue_ready),
		.ack(dequeue_ack),
		.response(l2_response),
		.reserve_en(reserve_en),
		.reserve_thread(reserve_thread),
		.reserve_addr(reserve_addr),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data)
	);
endmodule

/* include/core_config.svh */
/*
 * Core configuration macros for the store path.
 * Thread count, cache line size and the default L2 answer latency.
 */

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Hardware threads per core
`define THREADS_PER_CORE 4

// Bytes in one cache line
`define CACHE_LINE_BYTES 16

// Cycles from L2 accept to L2 answer
`define L2_DEFAULT_LATENCY 4

`endif
